//--- clint_subsys.f
+incdir+common
common/clint_pkg.sv
clint/clint_axi_slave.sv
clint/clint_regs.sv
src/clint_top.sv
verif/clint_tb.sv

//--- Makefile
# Verilator build and run for the CLINT testbench

LOG := sim.log

all: run

build:
	verilator --binary --timing --assert -f clint_subsys.f --top-module clint_tb -Mdir obj_dir

run: build
	./obj_dir/Vclint_tb > $(LOG) 2>&1; st=$$?; cat $(LOG); test $$st -eq 0
	@! grep -q "Simulation FAILED" $(LOG)

lint:
	verilator --lint-only --timing -f clint_subsys.f --top-module clint_tb

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

//--- verif/clint_tb.sv
// random CLINT testbench; mtime is only known to within one prescaler tick either side
`timescale 1ns/10ps
`include "clint_params.svh"

module clint_tb
  import clint_pkg::*;
();

  localparam logic [63:0] MSIP_A  = `CLINT_BASE + `CLINT_MSIP_OFS;
  localparam logic [63:0] CMP_A   = `CLINT_BASE + `CLINT_MTIMECMP_OFS;
  localparam logic [63:0] MTIME_A = `CLINT_BASE + `CLINT_MTIME_OFS;
  localparam longint unsigned TICK_DIV = 64'd1 << `CLINT_TICK_W;
  localparam int TIMEOUT = 100;

  logic       clk;
  logic       rst;
  logic       aw_valid;
  clint_ax_t  aw;
  logic       aw_ready;
  logic       w_valid;
  clint_w_t   w;
  logic       w_ready;
  logic       b_ready;
  logic       b_valid;
  clint_b_t   b;
  logic       ar_valid;
  clint_ax_t  ar;
  logic       ar_ready;
  logic       r_ready;
  logic       r_valid;
  clint_r_t   r;
  clint_irq_t irq;

  logic [31:0]     rng_state;
  int              errors;
  longint unsigned cyc = 64'd0;
  longint unsigned rd_cyc;
  // reference model
  logic [31:0]     m_msip;
  logic [63:0]     m_cmp;
  logic [63:0]     mt_base;
  longint unsigned mt_cyc;

  clint_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid),
    .aw_i       (aw),
    .aw_ready_o (aw_ready),
    .w_valid_i  (w_valid),
    .w_i        (w),
    .w_ready_o  (w_ready),
    .b_ready_i  (b_ready),
    .b_valid_o  (b_valid),
    .b_o        (b),
    .ar_valid_i (ar_valid),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_ready_i  (r_ready),
    .r_valid_o  (r_valid),
    .r_o        (r),
    .irq_o      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 64'd1;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) res[i*8 +: 8] = data[i*8 +: 8];
    end
    return res;
  endfunction

  // mtime window at a given cycle
  function automatic logic [63:0] mtime_lo(input longint unsigned at);
    longint unsigned ticks;
    ticks = (at - mt_cyc) / TICK_DIV;
    return mt_base + ((ticks > 0) ? ticks - 64'd1 : 64'd0);
  endfunction

  function automatic logic [63:0] mtime_hi(input longint unsigned at);
    return mt_base + (at - mt_cyc) / TICK_DIV + 64'd1;
  endfunction

  function automatic logic [63:0] unmapped_addr();
    logic [63:0] a;
    a = {next_rand(), next_rand()};
    // half of them land inside the CLINT window
    if (a[63]) a = `CLINT_BASE | {48'h0, a[15:0]};
    if (a == MSIP_A || a == CMP_A || a == MTIME_A) a = a ^ 64'h8;
    return a;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("ERROR t=%0t no %s within %0d cycles", $time, what, TIMEOUT);
    $display("errors: %0d, run aborted", errors + 1);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic model_write(input logic [63:0] addr, input logic [63:0] data,
                             input logic [7:0] strb);
    logic [63:0] tmp;
    if (addr == MSIP_A) begin
      tmp = merge_bytes({32'h0, m_msip}, data, strb);
      m_msip = tmp[31:0];
    end else if (addr == CMP_A) begin
      m_cmp = merge_bytes(m_cmp, data, strb);
    end else if (addr == MTIME_A) begin
      // only full-strobe writes reach mtime
      mt_base = data;
      mt_cyc  = cyc;
    end
  endtask

  task automatic axi_write(input logic [63:0] addr, input int beats, input bit full,
                           input logic [63:0] fixed);
    clint_ax_t   req;
    clint_w_t    beat;
    logic [31:0] tmp;
    int          n;
    int          hold;
    tmp = next_rand();
    req.addr = addr;
    req.id   = tmp[3:0];
    req.user = tmp[4];
    req.len  = 8'(beats - 1);
    aw_valid <= 1'b1;
    aw       <= req;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) stop_on_timeout("aw_ready");
    end while (!aw_ready);
    aw_valid <= 1'b0;
    for (int i = 0; i < beats; i++) begin
      tmp = next_rand();
      beat.data = full ? fixed : {next_rand(), next_rand()};
      beat.strb = full ? 8'hff : tmp[7:0];
      beat.last = (i == beats - 1);
      w_valid <= 1'b1;
      w       <= beat;
      n = 0;
      do begin
        @(posedge clk);
        n++;
        if (n > TIMEOUT) stop_on_timeout("w_ready");
      end while (!w_ready);
      model_write(addr, beat.data, beat.strb);
    end
    w_valid <= 1'b0;
    hold = int'(next_rand() % 32'd6);
    n = 0;
    do begin
      if (n == hold) b_ready <= 1'b1;
      @(posedge clk);
      n++;
      if (n > TIMEOUT) stop_on_timeout("b_valid");
      if (b_valid) check_eq("b_o", 64'({2'b00, req.id, req.user}), 64'(b));
    end while (!(b_valid && n > hold));
    b_ready <= 1'b0;
  endtask

  task automatic axi_read(input logic [63:0] addr, output logic [63:0] data);
    clint_ax_t   req;
    logic [63:0] snap;
    logic [31:0] tmp;
    bit          seen;
    int          n;
    int          hold;
    tmp = next_rand();
    req.addr = addr;
    req.id   = tmp[3:0];
    req.user = tmp[4];
    req.len  = tmp[15:8];
    ar_valid <= 1'b1;
    ar       <= req;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) stop_on_timeout("ar_ready");
    end while (!ar_ready);
    ar_valid <= 1'b0;
    hold = int'(next_rand() % 32'd6);
    seen = 1'b0;
    snap = '0;
    n = 0;
    do begin
      if (n == hold) r_ready <= 1'b1;
      @(posedge clk);
      n++;
      if (n > TIMEOUT) stop_on_timeout("r_valid");
      if (r_valid) begin
        check_eq("r_o.{resp,last,id,user}", 64'({2'b00, 1'b1, req.id, req.user}), 64'(r[7:0]));
        // mtime may tick while the beat waits
        if (seen && addr != MTIME_A) check_eq("r_o.data (held)", snap, r.data);
        snap = r.data;
        seen = 1'b1;
      end
    end while (!(r_valid && n > hold));
    r_ready <= 1'b0;
    data   = r.data;
    rd_cyc = cyc;
  endtask

  task automatic read_check(input logic [63:0] addr, output logic [63:0] data);
    logic [63:0] lo;
    logic [63:0] hi;
    axi_read(addr, data);
    if (addr == MSIP_A) begin
      check_eq("r_o.data (msip)", {{32{m_msip[31]}}, m_msip}, data);
    end else if (addr == CMP_A) begin
      check_eq("r_o.data (mtimecmp)", m_cmp, data);
    end else if (addr == MTIME_A) begin
      lo = mtime_lo(rd_cyc);
      hi = mtime_hi(rd_cyc);
      assert (data >= lo && data <= hi) else begin
        errors++;
        $display("ERROR t=%0t mtime read %h is outside %h to %h", $time, data, lo, hi);
      end
    end else begin
      check_eq("r_o.data (unmapped)", 64'h0, data);
    end
  endtask

  task automatic check_irq(input bit check_mti, input bit exp_mti);
    @(posedge clk);
    check_eq("irq_o.msi", 64'(m_msip[0]), 64'(irq.msi));
    if (check_mti) check_eq("irq_o.mti", 64'(exp_mti), 64'(irq.mti));
  endtask

  initial begin
    logic [63:0] rd0;
    logic [63:0] rd1;
    logic [63:0] addr;
    logic [63:0] val;
    logic [31:0] tmp;
    rng_state = 32'h29b242f8;
    errors    = 0;
    m_msip    = '0;
    m_cmp     = '0;
    mt_base   = '0;
    mt_cyc    = 0;
    rst       = 1'b1;
    aw_valid  = 1'b0;
    aw        = '0;
    w_valid   = 1'b0;
    w         = '0;
    b_ready   = 1'b0;
    ar_valid  = 1'b0;
    ar        = '0;
    r_ready   = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    mt_cyc = cyc;

    // strobed bursts into msip and mtimecmp
    for (int i = 0; i < 24; i++) begin
      tmp = next_rand();
      addr = tmp[0] ? MSIP_A : CMP_A;
      axi_write(addr, int'(tmp[2:1]) + 1, 1'b0, 64'h0);
      read_check(MSIP_A, rd0);
      read_check(CMP_A, rd0);
      check_irq(1'b0, 1'b0);
    end

    // unmapped accesses leave all registers alone
    for (int i = 0; i < 10; i++) begin
      tmp = next_rand();
      addr = unmapped_addr();
      axi_write(addr, int'(tmp[1:0]) + 1, 1'b0, 64'h0);
      read_check(addr, rd0);
      read_check(MSIP_A, rd0);
      read_check(CMP_A, rd0);
      read_check(MTIME_A, rd0);
    end

    // mtime set, then two reads some ticks apart
    for (int i = 0; i < 6; i++) begin
      val = {next_rand(), next_rand()} >> 4;
      axi_write(MTIME_A, 1, 1'b1, val);
      read_check(MTIME_A, rd0);
      tmp = next_rand();
      repeat (int'(tmp[6:0])) @(posedge clk);
      read_check(MTIME_A, rd1);
      assert (rd1 >= rd0) else begin
        errors++;
        $display("ERROR t=%0t mtime went backwards from %h to %h", $time, rd0, rd1);
      end
    end

    // timer interrupt against compare values on either side of mtime
    for (int i = 0; i < 6; i++) begin
      axi_write(CMP_A, 1, 1'b1, mtime_lo(cyc));
      check_irq(1'b1, 1'b1);
      axi_write(CMP_A, 1, 1'b1, mtime_hi(cyc) + 64'd1000);
      check_irq(1'b1, 1'b0);
      read_check(CMP_A, rd0);
    end

    repeat (5) @(posedge clk);
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- src/clint_top.sv
// CLINT top: AXI4 slave port in, msi/mti levels out; single hart, no error responses
`timescale 1ns/10ps
`include "clint_params.svh"

module clint_top
  import clint_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       aw_valid_i,
  input  clint_ax_t  aw_i,
  output logic       aw_ready_o,
  input  logic       w_valid_i,
  input  clint_w_t   w_i,
  output logic       w_ready_o,
  input  logic       b_ready_i,
  output logic       b_valid_o,
  output clint_b_t   b_o,
  input  logic       ar_valid_i,
  input  clint_ax_t  ar_i,
  output logic       ar_ready_o,
  input  logic       r_ready_i,
  output logic       r_valid_o,
  output clint_r_t   r_o,
  output clint_irq_t irq_o
);

  clint_reg_wr_t            reg_wr;
  logic [`CLINT_ADDR_W-1:0] rd_addr;
  logic [`CLINT_DATA_W-1:0] rd_data;

  clint_axi_slave u_axi_slave (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid_i),
    .aw_i       (aw_i),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i),
    .w_i        (w_i),
    .w_ready_o  (w_ready_o),
    .b_ready_i  (b_ready_i),
    .b_valid_o  (b_valid_o),
    .b_o        (b_o),
    .ar_valid_i (ar_valid_i),
    .ar_i       (ar_i),
    .ar_ready_o (ar_ready_o),
    .r_ready_i  (r_ready_i),
    .r_valid_o  (r_valid_o),
    .r_o        (r_o),
    .reg_wr_o   (reg_wr),
    .rd_addr_o  (rd_addr),
    .rd_data_i  (rd_data)
  );

  clint_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .reg_wr_i  (reg_wr),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data),
    .irq_o     (irq_o)
  );

endmodule

//--- clint/clint_regs.sv
// msip/mtimecmp/mtime for one hart; unmapped reads give zero, unmapped writes are dropped
`timescale 1ns/10ps
`include "clint_params.svh"

module clint_regs
  import clint_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  clint_reg_wr_t            reg_wr_i,
  input  logic [`CLINT_ADDR_W-1:0] rd_addr_i,
  output logic [`CLINT_DATA_W-1:0] rd_data_o,
  output clint_irq_t               irq_o
);

  localparam logic [`CLINT_ADDR_W-1:0] MSIP_ADDR     = `CLINT_BASE + `CLINT_MSIP_OFS;
  localparam logic [`CLINT_ADDR_W-1:0] MTIMECMP_ADDR = `CLINT_BASE + `CLINT_MTIMECMP_OFS;
  localparam logic [`CLINT_ADDR_W-1:0] MTIME_ADDR    = `CLINT_BASE + `CLINT_MTIME_OFS;

  logic [31:0]              msip_q;
  logic [`CLINT_DATA_W-1:0] mtimecmp_q;
  logic [`CLINT_DATA_W-1:0] mtime_q;
  logic [`CLINT_TICK_W-1:0] tick_q;
  logic [`CLINT_DATA_W-1:0] wr_mask;
  logic                     tick;

  // byte strobes expanded to a bit mask
  always_comb begin
    for (int i = 0; i < `CLINT_DATA_W / 8; i++) begin
      wr_mask[i*8 +: 8] = {8{reg_wr_i.strb[i]}};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      msip_q <= '0;
    end else if (reg_wr_i.en && reg_wr_i.addr == MSIP_ADDR) begin
      msip_q <= (msip_q & ~wr_mask[31:0]) | (reg_wr_i.data[31:0] & wr_mask[31:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp_q <= '0;
    end else if (reg_wr_i.en && reg_wr_i.addr == MTIMECMP_ADDR) begin
      mtimecmp_q <= (mtimecmp_q & ~wr_mask) | (reg_wr_i.data & wr_mask);
    end
  end

  // prescaler, wraps every 2**CLINT_TICK_W cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      tick_q <= '0;
    end else begin
      tick_q <= tick_q + 1'b1;
    end
  end

  assign tick = &tick_q;

  // software write wins over the tick
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
    end else if (reg_wr_i.en && reg_wr_i.addr == MTIME_ADDR) begin
      mtime_q <= (mtime_q & ~wr_mask) | (reg_wr_i.data & wr_mask);
    end else if (tick) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  always_comb begin
    case (rd_addr_i)
      MSIP_ADDR:     rd_data_o = {{32{msip_q[31]}}, msip_q};
      MTIMECMP_ADDR: rd_data_o = mtimecmp_q;
      MTIME_ADDR:    rd_data_o = mtime_q;
      default:       rd_data_o = '0;
    endcase
  end

  assign irq_o.msi = msip_q[0];
  assign irq_o.mti = (mtime_q >= mtimecmp_q);

endmodule

//--- clint/clint_axi_slave.sv
// AXI4 slave, one read and one write in flight; bursts collapse to a single address, resp always OKAY
`timescale 1ns/10ps
`include "clint_params.svh"

module clint_axi_slave
  import clint_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     aw_valid_i,
  input  clint_ax_t                aw_i,
  output logic                     aw_ready_o,

  input  logic                     w_valid_i,
  input  clint_w_t                 w_i,
  output logic                     w_ready_o,

  input  logic                     b_ready_i,
  output logic                     b_valid_o,
  output clint_b_t                 b_o,

  input  logic                     ar_valid_i,
  input  clint_ax_t                ar_i,
  output logic                     ar_ready_o,

  input  logic                     r_ready_i,
  output logic                     r_valid_o,
  output clint_r_t                 r_o,

  output clint_reg_wr_t            reg_wr_o,
  output logic [`CLINT_ADDR_W-1:0] rd_addr_o,
  input  logic [`CLINT_DATA_W-1:0] rd_data_i
);

  typedef enum logic {R_IDLE, R_READ} r_state_e;
  typedef enum logic [1:0] {W_IDLE, W_WRITE, W_RESP} w_state_e;

  r_state_e r_state_q;
  r_state_e r_state_nxt;
  w_state_e w_state_q;
  w_state_e w_state_nxt;

  logic ar_ready_q;
  logic aw_ready_q;

  logic [`CLINT_ADDR_W-1:0] rd_addr_q;
  logic [`CLINT_ID_W-1:0]   rd_id_q;
  logic [`CLINT_USER_W-1:0] rd_user_q;
  logic [`CLINT_ADDR_W-1:0] wr_addr_q;
  logic [`CLINT_ID_W-1:0]   wr_id_q;
  logic [`CLINT_USER_W-1:0] wr_user_q;

  logic ar_hs;
  logic r_hs;
  logic aw_hs;
  logic w_hs;
  logic b_hs;

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  // read side
  always_comb begin
    r_state_nxt = r_state_q;
    case (r_state_q)
      R_IDLE:  if (ar_hs) r_state_nxt = R_READ;
      R_READ:  if (r_hs)  r_state_nxt = R_IDLE;
      default: r_state_nxt = R_IDLE;
    endcase
  end

  // ready is a flop so it stays low through reset
  always_ff @(posedge clk) begin
    if (rst) begin
      r_state_q  <= R_IDLE;
      ar_ready_q <= 1'b0;
    end else begin
      r_state_q  <= r_state_nxt;
      ar_ready_q <= (r_state_nxt == R_IDLE);
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_addr_q <= ar_i.addr;
      rd_id_q   <= ar_i.id;
      rd_user_q <= ar_i.user;
    end
  end

  assign ar_ready_o = ar_ready_q;
  assign rd_addr_o  = rd_addr_q;
  assign r_valid_o  = (r_state_q == R_READ);
  assign r_o.data   = rd_data_i;
  assign r_o.resp   = 2'b00;
  assign r_o.last   = 1'b1;
  assign r_o.id     = rd_id_q;
  assign r_o.user   = rd_user_q;

  // write side
  always_comb begin
    w_state_nxt = w_state_q;
    case (w_state_q)
      W_IDLE:  if (aw_hs) w_state_nxt = W_WRITE;
      W_WRITE: if (w_hs && w_i.last) w_state_nxt = W_RESP;
      W_RESP:  if (b_hs) w_state_nxt = W_IDLE;
      default: w_state_nxt = W_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      w_state_q  <= W_IDLE;
      aw_ready_q <= 1'b0;
    end else begin
      w_state_q  <= w_state_nxt;
      aw_ready_q <= (w_state_nxt == W_IDLE);
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_addr_q <= aw_i.addr;
      wr_id_q   <= aw_i.id;
      wr_user_q <= aw_i.user;
    end
  end

  assign aw_ready_o = aw_ready_q;
  assign w_ready_o  = (w_state_q == W_WRITE);

  // every beat hits the captured address
  assign reg_wr_o.en   = w_hs;
  assign reg_wr_o.addr = wr_addr_q;
  assign reg_wr_o.data = w_i.data;
  assign reg_wr_o.strb = w_i.strb;

  assign b_valid_o = (w_state_q == W_RESP);
  assign b_o.resp  = 2'b00;
  assign b_o.id    = wr_id_q;
  assign b_o.user  = wr_user_q;

endmodule

//--- common/clint_pkg.sv
// AXI channel and register access types for the CLINT; prot/lock/cache/qos/size/burst not carried
`include "clint_params.svh"

package clint_pkg;

  // AW or AR request, len is accepted but ignored
  typedef struct packed {
    logic [`CLINT_ADDR_W-1:0] addr;
    logic [`CLINT_ID_W-1:0]   id;
    logic [`CLINT_USER_W-1:0] user;
    logic [7:0]               len;
  } clint_ax_t;

  typedef struct packed {
    logic [`CLINT_DATA_W-1:0]   data;
    logic [`CLINT_DATA_W/8-1:0] strb;
    logic                       last;
  } clint_w_t;

  typedef struct packed {
    logic [1:0]               resp;
    logic [`CLINT_ID_W-1:0]   id;
    logic [`CLINT_USER_W-1:0] user;
  } clint_b_t;

  typedef struct packed {
    logic [`CLINT_DATA_W-1:0] data;
    logic [1:0]               resp;
    logic                     last;
    logic [`CLINT_ID_W-1:0]   id;
    logic [`CLINT_USER_W-1:0] user;
  } clint_r_t;

  // one strobed register write per W beat
  typedef struct packed {
    logic                       en;
    logic [`CLINT_ADDR_W-1:0]   addr;
    logic [`CLINT_DATA_W-1:0]   data;
    logic [`CLINT_DATA_W/8-1:0] strb;
  } clint_reg_wr_t;

  typedef struct packed {
    logic msi;
    logic mti;
  } clint_irq_t;

endpackage

//--- common/clint_params.svh
// single hart CLINT constants; base and offsets are full 64-bit byte addresses
`ifndef CLINT_PARAMS_SVH
`define CLINT_PARAMS_SVH

// bus widths
`define CLINT_DATA_W 64
`define CLINT_ADDR_W 64
`define CLINT_ID_W   4
`define CLINT_USER_W 1

// memory map
`define CLINT_BASE         64'h0000_0000_0200_0000
`define CLINT_MSIP_OFS     64'h0000_0000_0000_0000
`define CLINT_MTIMECMP_OFS 64'h0000_0000_0000_4000
`define CLINT_MTIME_OFS    64'h0000_0000_0000_BFF8

// mtime advances once per 2**CLINT_TICK_W cycles
`define CLINT_TICK_W 5

`endif
